// ==== run_sim.sh ====
#!/bin/bash
# Build and run the CPU testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --assert --timing -Wno-fatal --top-module cpu_tb -f sim.f \
	-o cpu_sim > build.log 2>&1 || { cat build.log; echo "Build failed"; exit 1; }

./obj_dir/cpu_sim > sim.log 2>&1
cat sim.log

! grep -q "Something failed" sim.log && grep -q "Everything OK" sim.log \
	&& { echo "PASS"; exit 0; } || { echo "FAIL"; exit 1; }

// ==== sim.f ====
source/cpu_pkg.sv
source/reg_port_if.sv
source/alu.sv
source/reg_file.sv
source/instr_decode.sv
source/cpu_ctl.sv
source/cpu.sv
testbench/cpu_assertions.sv
testbench/cpu_tb.sv

// ==== source/alu.sv ====
`timescale 1ns/10ps

module alu(
	input  logic             __clk,
	input  logic             rst_n,
	input  cpu_pkg::alu_op_e op,
	input  cpu_pkg::word_t   operand_a,
	input  cpu_pkg::word_t   operand_b,
	input  logic             flag_we,
	output cpu_pkg::word_t   result,
	output logic             zero
);

	cpu_pkg::word_t res;
	logic           zero_flag;

	always_comb begin
		case (op)
			cpu_pkg::alu_add: res = operand_a + operand_b;
			cpu_pkg::alu_sub: res = operand_a - operand_b;
			cpu_pkg::alu_or:  res = operand_a | operand_b;
			cpu_pkg::alu_and: res = operand_a & operand_b;
			cpu_pkg::alu_xor: res = operand_a ^ operand_b;
			default:          res = operand_b;
		endcase
	end

	assign result = res;

	// Flag register, updated only on request
	always_ff @(posedge __clk) begin
		if (!rst_n) begin
			zero_flag <= 1'b0;
		end else if (flag_we) begin
			zero_flag <= (res == '0);
		end
	end

	assign zero = zero_flag;

endmodule

// ==== source/cpu.sv ====
`timescale 1ns/10ps

module cpu(
	input  logic           __clk,
	input  logic           rst_n,

	// memory bus
	output logic           mem_valid,
	input  logic           mem_ready,
	output logic           mem_we,
	output cpu_pkg::word_t mem_addr,
	output cpu_pkg::word_t mem_wdata,
	input  cpu_pkg::word_t mem_rdata,

	// status
	output logic           halted,
	output logic           alarm
);

	cpu_pkg::decoded_t decoded;
	cpu_pkg::word_t    instr;
	cpu_pkg::word_t    alu_a, alu_b, alu_result;
	logic              flag_we, zero;

	reg_port_if rp();

// --------------------------------------------------
// --- Control --------------------------------------
// --------------------------------------------------

	cpu_ctl ctl(
		.__clk(__clk),
		.rst_n(rst_n),
		.decoded(decoded),
		.instr(instr),
		.regs(rp.ctl),
		.alu_a(alu_a),
		.alu_b(alu_b),
		.flag_we(flag_we),
		.alu_result(alu_result),
		.zero(zero),
		.mem_valid(mem_valid),
		.mem_ready(mem_ready),
		.mem_we(mem_we),
		.mem_addr(mem_addr),
		.mem_wdata(mem_wdata),
		.mem_rdata(mem_rdata),
		.halted(halted),
		.alarm(alarm)
	);

// --------------------------------------------------
// --- Decode ---------------------------------------
// --------------------------------------------------

	instr_decode dec(
		.instr(instr),
		.decoded(decoded)
	);

// --------------------------------------------------
// --- Registers and arithmetic ---------------------
// --------------------------------------------------

	reg_file rf(
		.__clk(__clk),
		.rst_n(rst_n),
		.port(rp.regs)
	);

	alu arith(
		.__clk(__clk),
		.rst_n(rst_n),
		.op(decoded.alu_op),
		.operand_a(alu_a),
		.operand_b(alu_b),
		.flag_we(flag_we),
		.result(alu_result),
		.zero(zero)
	);

endmodule

// ==== source/cpu_ctl.sv ====
`timescale 1ns/10ps

module cpu_ctl(
	input  logic              __clk,
	input  logic              rst_n,
	input  cpu_pkg::decoded_t decoded,
	output cpu_pkg::word_t    instr,
	reg_port_if.ctl           regs,
	output cpu_pkg::word_t    alu_a,
	output cpu_pkg::word_t    alu_b,
	output logic              flag_we,
	input  cpu_pkg::word_t    alu_result,
	input  logic              zero,
	output logic              mem_valid,
	input  logic              mem_ready,
	output logic              mem_we,
	output cpu_pkg::word_t    mem_addr,
	output cpu_pkg::word_t    mem_wdata,
	input  cpu_pkg::word_t    mem_rdata,
	output logic              halted,
	output logic              alarm
);

	cpu_pkg::ctl_state_e state;
	cpu_pkg::word_t      ic;
	cpu_pkg::word_t      ir;
	cpu_pkg::word_t      load_data;
	cpu_pkg::word_t      eff_addr;
	cpu_pkg::word_t      next_ic;
	logic                jump_taken;
	logic                exec_reg_op;

	assign instr  = ir;
	assign halted = (state == cpu_pkg::st_halt);
	assign alarm  = (state == cpu_pkg::st_alarm);

	// Operand selection
	assign regs.ra_num = decoded.a;
	assign regs.rb_num = decoded.b;
	assign alu_a = regs.ra_data;
	assign alu_b = (decoded.alu_op == cpu_pkg::alu_pass_b) ? decoded.arg : regs.rb_data;

	// B+arg serves loads, stores and jumps
	assign eff_addr   = regs.rb_data + decoded.arg;
	assign jump_taken = decoded.is_jump && (!decoded.is_cond || zero);
	assign next_ic    = jump_taken ? eff_addr : ic;

	assign exec_reg_op = (state == cpu_pkg::st_exec) && decoded.writes_reg
		&& !decoded.uses_mem;

	// Flags follow the logic and arithmetic ops only, not lwt
	assign flag_we = exec_reg_op && (decoded.alu_op != cpu_pkg::alu_pass_b);

	// Write-back
	assign regs.wr_en   = exec_reg_op || (state == cpu_pkg::st_wb);
	assign regs.wr_num  = decoded.a;
	assign regs.wr_data = (state == cpu_pkg::st_wb) ? load_data : alu_result;

// --------------------------------------------------
// --- Sequencer ------------------------------------
// --------------------------------------------------

	always_ff @(posedge __clk) begin
		if (!rst_n) begin
			state     <= cpu_pkg::st_fetch;
			ic        <= cpu_pkg::RESET_IC;
			mem_valid <= 1'b0;
			mem_we    <= 1'b0;
		end else begin
			case (state)
				cpu_pkg::st_fetch: begin
					if (!mem_valid) begin
						// first fetch after reset
						mem_valid <= 1'b1;
						mem_we    <= 1'b0;
					end else if (mem_ready) begin
						mem_valid <= 1'b0;
						ic        <= ic + 1'b1;
						state     <= cpu_pkg::st_exec;
					end
				end
				cpu_pkg::st_exec: begin
					if (decoded.illegal) begin
						state <= cpu_pkg::st_alarm;
					end else if (decoded.is_halt) begin
						state <= cpu_pkg::st_halt;
					end else if (decoded.uses_mem) begin
						mem_valid <= 1'b1;
						mem_we    <= decoded.mem_store;
						state     <= cpu_pkg::st_mem;
					end else begin
						// Next fetch goes out straight away
						mem_valid <= 1'b1;
						mem_we    <= 1'b0;
						ic        <= next_ic;
						state     <= cpu_pkg::st_fetch;
					end
				end
				cpu_pkg::st_mem: begin
					if (mem_ready) begin
						if (decoded.mem_store) begin
							mem_we <= 1'b0;
							state  <= cpu_pkg::st_fetch;
						end else begin
							mem_valid <= 1'b0;
							state     <= cpu_pkg::st_wb;
						end
					end
				end
				cpu_pkg::st_wb: begin
					mem_valid <= 1'b1;
					mem_we    <= 1'b0;
					state     <= cpu_pkg::st_fetch;
				end
				default: begin
					// Halt and alarm hold until reset
					mem_valid <= 1'b0;
				end
			endcase
		end
	end

	// Bus payload and instruction register
	always_ff @(posedge __clk) begin
		case (state)
			cpu_pkg::st_fetch: begin
				if (!mem_valid) begin
					mem_addr <= ic;
				end else if (mem_ready) begin
					ir <= mem_rdata;
				end
			end
			cpu_pkg::st_exec: begin
				if (decoded.uses_mem) begin
					mem_addr  <= eff_addr;
					mem_wdata <= regs.ra_data;
				end else begin
					mem_addr <= next_ic;
				end
			end
			cpu_pkg::st_mem: begin
				if (mem_ready) begin
					load_data <= mem_rdata;
					mem_addr  <= ic;
				end
			end
			default: begin
			end
		endcase
	end

endmodule

// ==== source/cpu_pkg.sv ====
package cpu_pkg;

	// Machine geometry
	localparam int WORD_W  = 16;
	localparam int REG_CNT = 8;
	localparam int REG_AW  = 3;
	localparam int ARG_W   = 6;

	// Bit 0 is the most significant bit
	typedef logic [0:WORD_W-1] word_t;
	typedef logic [0:REG_AW-1] reg_num_t;

	localparam word_t RESET_IC = 16'h0000;

	// Opcode field, instruction bits 0..3
	typedef enum logic [3:0] {
		op_lw  = 4'd1,
		op_rw  = 4'd2,
		op_aw  = 4'd3,
		op_sw  = 4'd4,
		op_or  = 4'd5,
		op_nr  = 4'd6,
		op_er  = 4'd7,
		op_lwt = 4'd8,
		op_uj  = 4'd9,
		op_jz  = 4'd10,
		op_hlt = 4'd11
	} opcode_e;

	typedef enum logic [2:0] {
		alu_add,
		alu_sub,
		alu_or,
		alu_and,
		alu_xor,
		alu_pass_b
	} alu_op_e;

	typedef enum logic [2:0] {
		st_fetch,
		st_exec,
		st_mem,
		st_wb,
		st_halt,
		st_alarm
	} ctl_state_e;

	// Decoder output, one instruction
	typedef struct packed {
		opcode_e  opcode;
		reg_num_t a;
		reg_num_t b;
		word_t    arg;
		alu_op_e  alu_op;
		logic     writes_reg;
		logic     uses_mem;
		logic     mem_store;
		logic     is_jump;
		logic     is_cond;
		logic     is_halt;
		logic     illegal;
	} decoded_t;

endpackage

// ==== source/instr_decode.sv ====
`timescale 1ns/10ps

module instr_decode(
	input  cpu_pkg::word_t    instr,
	output cpu_pkg::decoded_t decoded
);

	cpu_pkg::opcode_e opc;

	assign opc = cpu_pkg::opcode_e'(instr[0:3]);

	always_comb begin
		decoded        = '0;
		decoded.opcode = opc;
		decoded.a      = instr[4:6];
		decoded.b      = instr[7:9];
		// 6-bit short argument, sign bit is instr[10]
		decoded.arg    = {{(cpu_pkg::WORD_W - cpu_pkg::ARG_W){instr[10]}}, instr[10:15]};
		decoded.alu_op = cpu_pkg::alu_pass_b;

		case (opc)
			cpu_pkg::op_lw: begin
				decoded.writes_reg = 1'b1;
				decoded.uses_mem   = 1'b1;
			end
			cpu_pkg::op_rw: begin
				decoded.uses_mem  = 1'b1;
				decoded.mem_store = 1'b1;
			end
			cpu_pkg::op_aw: begin
				decoded.writes_reg = 1'b1;
				decoded.alu_op     = cpu_pkg::alu_add;
			end
			cpu_pkg::op_sw: begin
				decoded.writes_reg = 1'b1;
				decoded.alu_op     = cpu_pkg::alu_sub;
			end
			cpu_pkg::op_or: begin
				decoded.writes_reg = 1'b1;
				decoded.alu_op     = cpu_pkg::alu_or;
			end
			cpu_pkg::op_nr: begin
				decoded.writes_reg = 1'b1;
				decoded.alu_op     = cpu_pkg::alu_and;
			end
			cpu_pkg::op_er: begin
				decoded.writes_reg = 1'b1;
				decoded.alu_op     = cpu_pkg::alu_xor;
			end
			cpu_pkg::op_lwt: decoded.writes_reg = 1'b1;
			cpu_pkg::op_uj:  decoded.is_jump = 1'b1;
			cpu_pkg::op_jz: begin
				decoded.is_jump = 1'b1;
				decoded.is_cond = 1'b1;
			end
			cpu_pkg::op_hlt: decoded.is_halt = 1'b1;
			default: decoded.illegal = 1'b1;
		endcase
	end

endmodule

// ==== source/reg_file.sv ====
`timescale 1ns/10ps

module reg_file(
	input  logic    __clk,
	input  logic    rst_n,
	reg_port_if.regs port
);

	cpu_pkg::word_t regs_q [cpu_pkg::REG_CNT];

	// Single write port
	always_ff @(posedge __clk) begin
		if (!rst_n) begin
			for (int i = 0; i < cpu_pkg::REG_CNT; i++) begin
				regs_q[i] <= '0;
			end
		end else if (port.wr_en) begin
			regs_q[port.wr_num] <= port.wr_data;
		end
	end

	// Two asynchronous read ports
	assign port.ra_data = regs_q[port.ra_num];
	assign port.rb_data = regs_q[port.rb_num];

endmodule

// ==== source/reg_port_if.sv ====
`timescale 1ns/10ps

// Register file access from the control module
interface reg_port_if;

	// Read side
	cpu_pkg::reg_num_t ra_num;
	cpu_pkg::reg_num_t rb_num;
	cpu_pkg::word_t    ra_data;
	cpu_pkg::word_t    rb_data;

	// Write side
	logic              wr_en;
	cpu_pkg::reg_num_t wr_num;
	cpu_pkg::word_t    wr_data;

	modport ctl (
		output ra_num, rb_num, wr_en, wr_num, wr_data,
		input  ra_data, rb_data
	);

	modport regs (
		input  ra_num, rb_num, wr_en, wr_num, wr_data,
		output ra_data, rb_data
	);

endinterface

// ==== testbench/cpu_assertions.sv ====
`timescale 1ns/10ps

module cpu_assertions(
	input logic           __clk,
	input logic           rst_n,
	input logic           mem_valid,
	input logic           mem_ready,
	input logic           mem_we,
	input cpu_pkg::word_t mem_addr,
	input cpu_pkg::word_t mem_wdata,
	input logic           halted,
	input logic           alarm
);

	int fail_count = 0;

	// Bus idle straight after a reset cycle
	valid_low_after_reset: assert property (@(posedge __clk) !rst_n |=> !mem_valid)
		else begin
			$error("mem_valid high after reset");
			fail_count++;
		end

	// Request held while the memory stalls
	request_stable: assert property (@(posedge __clk) disable iff (!rst_n)
		mem_valid && !mem_ready |=> mem_valid && $stable(mem_we) && $stable(mem_addr)
		&& $stable(mem_wdata))
		else begin
			$error("bus request changed during a stall");
			fail_count++;
		end

	no_valid_when_stopped: assert property (@(posedge __clk) disable iff (!rst_n)
		(halted || alarm) |-> !mem_valid)
		else begin
			$error("mem_valid high while stopped");
			fail_count++;
		end

	// Halt and alarm hold until reset
	stop_held: assert property (@(posedge __clk) disable iff (!rst_n)
		(halted || alarm) |=> $stable(halted) && $stable(alarm))
		else begin
			$error("halted or alarm changed before reset");
			fail_count++;
		end

endmodule

bind cpu cpu_assertions bus_check(
	.__clk(__clk),
	.rst_n(rst_n),
	.mem_valid(mem_valid),
	.mem_ready(mem_ready),
	.mem_we(mem_we),
	.mem_addr(mem_addr),
	.mem_wdata(mem_wdata),
	.halted(halted),
	.alarm(alarm)
);

// ==== testbench/cpu_tb.sv ====
`timescale 1ns/10ps

module cpu_tb;

	logic           __clk;
	logic           rst_n;
	logic           mem_valid;
	logic           mem_ready;
	logic           mem_we;
	cpu_pkg::word_t mem_addr;
	cpu_pkg::word_t mem_wdata;
	cpu_pkg::word_t mem_rdata;
	logic           halted;
	logic           alarm;

	cpu_pkg::word_t mem      [256];
	cpu_pkg::word_t init_mem [256];
	logic [15:0]    lfsr;

	// Model results
	cpu_pkg::word_t exp_addr [$];
	cpu_pkg::word_t exp_data [$];
	logic           exp_halt;
	logic           exp_alarm;
	cpu_pkg::word_t exp_ic;
	int             store_idx;

	cpu UUT(
		.__clk(__clk),
		.rst_n(rst_n),
		.mem_valid(mem_valid),
		.mem_ready(mem_ready),
		.mem_we(mem_we),
		.mem_addr(mem_addr),
		.mem_wdata(mem_wdata),
		.mem_rdata(mem_rdata),
		.halted(halted),
		.alarm(alarm)
	);

	always #4 __clk = ~__clk;

	assign mem_rdata = mem[mem_addr[8:15]];

	task automatic stop_on_error(input string line);
		$display("%s", line);
		$display("Something failed");
		$fatal(1, "simulation stopped at first error");
	endtask

	function automatic logic [15:0] lfsr_next(input logic [15:0] s);
		return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
	endfunction

	function automatic cpu_pkg::word_t enc(input cpu_pkg::opcode_e op, input int a,
		input int b, input int arg);
		logic [5:0] a6;
		a6 = arg[5:0];
		return {4'(op), 3'(a), 3'(b), a6};
	endfunction

// --------------------------------------------------
// --- Reference model ------------------------------
// --------------------------------------------------

	function automatic void cpu_model();
		cpu_pkg::word_t m [256];
		cpu_pkg::word_t r [8];
		cpu_pkg::word_t ic;
		cpu_pkg::word_t iw;
		cpu_pkg::word_t arg;
		cpu_pkg::word_t addr;
		cpu_pkg::word_t res;
		logic [3:0]     op;
		logic [2:0]     a;
		logic [2:0]     b;
		logic           zf;
		logic           done;
		for (int i = 0; i < 256; i++) m[i] = init_mem[i];
		for (int i = 0; i < 8; i++) r[i] = '0;
		exp_addr.delete();
		exp_data.delete();
		ic = cpu_pkg::RESET_IC;
		zf = 1'b0;
		done = 1'b0;
		exp_halt = 1'b0;
		exp_alarm = 1'b0;
		for (int step = 0; step < 1000 && !done; step++) begin
			iw = m[ic[8:15]];
			ic = ic + 16'd1;
			op = iw[0:3];
			a = iw[4:6];
			b = iw[7:9];
			arg = {{10{iw[10]}}, iw[10:15]};
			addr = r[b] + arg;
			case (op)
				4'd1: r[a] = m[addr[8:15]];
				4'd2: begin
					exp_addr.push_back(addr);
					exp_data.push_back(r[a]);
					m[addr[8:15]] = r[a];
				end
				4'd3, 4'd4, 4'd5, 4'd6, 4'd7: begin
					case (op)
						4'd3: res = r[a] + r[b];
						4'd4: res = r[a] - r[b];
						4'd5: res = r[a] | r[b];
						4'd6: res = r[a] & r[b];
						default: res = r[a] ^ r[b];
					endcase
					r[a] = res;
					zf = (res == '0);
				end
				4'd8: r[a] = arg;
				4'd9: ic = addr;
				4'd10: if (zf) ic = addr;
				4'd11: begin
					exp_halt = 1'b1;
					done = 1'b1;
				end
				default: begin
					exp_alarm = 1'b1;
					done = 1'b1;
				end
			endcase
		end
		exp_ic = ic;
	endfunction

// --------------------------------------------------
// --- Checks ---------------------------------------
// --------------------------------------------------

	task automatic check_store(input cpu_pkg::word_t addr, input cpu_pkg::word_t data);
		if (addr !== exp_addr[store_idx] || data !== exp_data[store_idx])
			stop_on_error($sformatf("[FAIL] %0t: store %0d wrote %h to %h, expected %h to %h",
				$time, store_idx, data, addr, exp_data[store_idx], exp_addr[store_idx]));
	endtask

	task automatic check_stop(input logic h, input logic al);
		if (h !== exp_halt || al !== exp_alarm)
			stop_on_error($sformatf("[FAIL] %0t: halted/alarm %b/%b, expected %b/%b",
				$time, h, al, exp_halt, exp_alarm));
	endtask

	task automatic check_ic(input cpu_pkg::word_t ic);
		if (ic !== exp_ic)
			stop_on_error($sformatf("[FAIL] %0t: final instruction counter %h, expected %h",
				$time, ic, exp_ic));
	endtask

	// Memory writes and store comparison
	always @(posedge __clk) begin
		if (rst_n && mem_valid && mem_ready && mem_we) begin
			mem[mem_addr[8:15]] <= mem_wdata;
			if (store_idx >= exp_addr.size())
				stop_on_error($sformatf("Unexpected extra store to %h at %0t", mem_addr, $time));
			else
				check_store(mem_addr, mem_wdata);
			store_idx++;
		end
	end

	// Random stalls, ready about three times in four
	always @(posedge __clk) begin
		logic b1;
		logic b2;
		b1 = lfsr[0];
		lfsr = lfsr_next(lfsr);
		b2 = lfsr[0];
		lfsr = lfsr_next(lfsr);
		mem_ready <= b1 | b2;
	end

	task automatic load_program(input int prog);
		for (int i = 0; i < 256; i++) init_mem[i] = {i[7:0], ~i[7:0]} ^ 16'h3C5A;
		if (prog == 1) begin
			init_mem[0]  = enc(cpu_pkg::op_lwt, 1, 0, 5);
			init_mem[1]  = enc(cpu_pkg::op_lwt, 2, 0, -3);
			init_mem[2]  = enc(cpu_pkg::op_lwt, 5, 0, 24);
			init_mem[3]  = enc(cpu_pkg::op_aw, 5, 5, 0);
			init_mem[4]  = enc(cpu_pkg::op_lwt, 7, 0, 24);
			init_mem[5]  = enc(cpu_pkg::op_aw, 7, 7, 0);
			init_mem[6]  = enc(cpu_pkg::op_aw, 7, 7, 0);
			init_mem[7]  = enc(cpu_pkg::op_lw, 3, 5, 2);
			init_mem[8]  = enc(cpu_pkg::op_lw, 6, 5, -1);
			init_mem[9]  = enc(cpu_pkg::op_rw, 1, 7, 0);
			init_mem[10] = enc(cpu_pkg::op_rw, 2, 7, 1);
			init_mem[11] = enc(cpu_pkg::op_rw, 3, 7, 2);
			init_mem[12] = enc(cpu_pkg::op_rw, 6, 7, 3);
			init_mem[13] = enc(cpu_pkg::op_aw, 3, 1, 0);
			init_mem[14] = enc(cpu_pkg::op_rw, 3, 7, 4);
			init_mem[15] = enc(cpu_pkg::op_sw, 3, 2, 0);
			init_mem[16] = enc(cpu_pkg::op_rw, 3, 7, 5);
			init_mem[17] = enc(cpu_pkg::op_or, 3, 6, 0);
			init_mem[18] = enc(cpu_pkg::op_rw, 3, 7, 6);
			init_mem[19] = enc(cpu_pkg::op_nr, 3, 6, 0);
			init_mem[20] = enc(cpu_pkg::op_rw, 3, 7, 7);
			init_mem[21] = enc(cpu_pkg::op_er, 3, 1, 0);
			init_mem[22] = enc(cpu_pkg::op_rw, 3, 7, 8);
			init_mem[23] = enc(cpu_pkg::op_uj, 0, 0, 26);
			init_mem[24] = enc(cpu_pkg::op_rw, 1, 7, 31);
			init_mem[25] = enc(cpu_pkg::op_hlt, 0, 0, 0);
			// Zero flag set, then lwt must leave it alone
			init_mem[26] = enc(cpu_pkg::op_sw, 1, 1, 0);
			init_mem[27] = enc(cpu_pkg::op_lwt, 1, 0, 7);
			init_mem[28] = enc(cpu_pkg::op_jz, 0, 0, 30);
			init_mem[29] = enc(cpu_pkg::op_rw, 2, 7, 30);
			init_mem[30] = enc(cpu_pkg::op_rw, 1, 7, 9);
			init_mem[31] = enc(cpu_pkg::op_aw, 1, 2, 0);
			init_mem[32] = enc(cpu_pkg::op_jz, 0, 0, 36);
			init_mem[33] = enc(cpu_pkg::op_rw, 1, 7, 10);
			init_mem[34] = enc(cpu_pkg::op_lwt, 4, 0, -32);
			init_mem[35] = enc(cpu_pkg::op_rw, 4, 7, 11);
			init_mem[36] = enc(cpu_pkg::op_hlt, 0, 0, 0);
		end else begin
			init_mem[0] = enc(cpu_pkg::op_lwt, 1, 0, -1);
			init_mem[1] = enc(cpu_pkg::op_rw, 1, 0, 31);
			init_mem[2] = 16'hF000;
			init_mem[3] = enc(cpu_pkg::op_rw, 1, 0, 30);
		end
		for (int i = 0; i < 256; i++) mem[i] = init_mem[i];
	endtask

	task automatic run_program(input int prog);
		int n;
		@(posedge __clk);
		rst_n <= 1'b0;
		load_program(prog);
		cpu_model();
		store_idx = 0;
		repeat (16) @(posedge __clk);
		rst_n <= 1'b1;
		n = 0;
		while (!(halted || alarm) && n < 5000) begin
			@(posedge __clk);
			n++;
		end
		if (!(halted || alarm))
			stop_on_error($sformatf("Timeout: program %0d never reached halt or alarm", prog));
		if (store_idx != exp_addr.size())
			stop_on_error($sformatf("Program %0d made %0d stores, model expects %0d",
				prog, store_idx, exp_addr.size()));
		check_stop(halted, alarm);
		check_ic(UUT.ctl.ic);
		// Quiet window, no more bus requests
		n = 0;
		while (n < 40) begin
			@(posedge __clk);
			if (mem_valid)
				stop_on_error($sformatf("Bus request after stop in program %0d", prog));
			n++;
		end
		check_stop(halted, alarm);
	endtask

	initial begin
		__clk = 1'b0;
		rst_n = 1'b0;
		mem_ready = 1'b0;
		lfsr = 16'd20;
		store_idx = 0;
		run_program(1);
		run_program(2);
		if (UUT.bus_check.fail_count != 0)
			stop_on_error($sformatf("Bus protocol assertions failed %0d times",
				UUT.bus_check.fail_count));
		else begin
			$display("Everything OK");
			$finish;
		end
	end

endmodule
